// File: Bender.yml
package:
  name: rv32_decode_stage

sources:
  - hdl/rv32_decode_pkg.sv
  - hdl/control_decoder.sv
  - hdl/imm_generator.sv
  - hdl/decode_register.sv
  - hdl/decode_stage.sv
  - target: test
    files:
      - testbench/tb_decode_stage.sv

// File: files.f
hdl/rv32_decode_pkg.sv
hdl/control_decoder.sv
hdl/imm_generator.sv
hdl/decode_register.sv
hdl/decode_stage.sv
testbench/tb_decode_stage.sv

// File: hdl/control_decoder.sv
//######################################################################
// control decoder
// derives every execute-stage control field and the illegal flag
// from opcode, funct3 and funct7 of one instruction word
//######################################################################

`timescale 1ns/1ps

module control_decoder (
  input  rv32_decode_pkg::word_t    instr_i,
  output rv32_decode_pkg::imm_fmt_t imm_fmt_o,
  output rv32_decode_pkg::alu_op_t  alu_op_o,
  output rv32_decode_pkg::src_a_t   src_a_o,
  output rv32_decode_pkg::src_b_t   src_b_o,
  output rv32_decode_pkg::w_src_t   w_src_o,
  output logic                      reg_wen_o,
  output logic                      mem_ren_o,
  output logic                      mem_wen_o,
  output rv32_decode_pkg::load_t    load_type_o,
  output logic                      branch_o,
  output rv32_decode_pkg::branch_t  branch_type_o,
  output logic                      jump_o,
  output rv32_decode_pkg::sfu_t     sfu_o,
  output logic                      mul_high_o,
  output logic                      div_rem_o,
  output logic                      is_signed_o,
  output rv32_decode_pkg::csr_op_t  csr_op_o,
  output logic                      csr_imm_o,
  output rv32_decode_pkg::sys_op_t  sys_op_o,
  output logic                      illegal_o
);
  import rv32_decode_pkg::*;

  opcode_t     opcode;
  funct3_t     funct3;
  funct7_t     funct7;
  reg_idx_t    rd;
  logic [11:0] imm12;

  assign opcode = opcode_t'(instr_i[6:0]);
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign imm12  = instr_i[31:20];

  // ALU op, add unless an integer op says otherwise
  always_comb begin
    alu_op_o = ALU_ADD;
    if (opcode == IMMED || opcode == REGREG) begin
      case (funct3)
        F3_ADD:  alu_op_o = (opcode == REGREG && instr_i[30]) ? ALU_SUB : ALU_ADD;
        F3_SLL:  alu_op_o = ALU_SLL;
        F3_SLT:  alu_op_o = ALU_SLT;
        F3_SLTU: alu_op_o = ALU_SLTU;
        F3_XOR:  alu_op_o = ALU_XOR;
        F3_SR:   alu_op_o = instr_i[30] ? ALU_SRA : ALU_SRL;
        F3_OR:   alu_op_o = ALU_OR;
        F3_AND:  alu_op_o = ALU_AND;
        default: alu_op_o = ALU_ADD;
      endcase
    end
  end

  // per-opcode controls
  always_comb begin
    imm_fmt_o = IMM_NONE;
    src_a_o   = SRC_A_REG;
    src_b_o   = SRC_B_REG;
    w_src_o   = W_ALU;
    reg_wen_o = 1'b0;
    mem_ren_o = 1'b0;
    mem_wen_o = 1'b0;
    branch_o  = 1'b0;
    jump_o    = 1'b0;
    csr_op_o  = CSR_NONE;
    csr_imm_o = 1'b0;
    sys_op_o  = SYS_NONE;
    illegal_o = 1'b0;

    case (opcode)
      LOAD: begin
        imm_fmt_o = IMM_I;
        src_b_o   = SRC_B_IMM;
        w_src_o   = W_MEM;
        reg_wen_o = 1'b1;
        mem_ren_o = 1'b1;
      end
      STORE: begin
        imm_fmt_o = IMM_S;
        src_b_o   = SRC_B_IMM;
        mem_wen_o = 1'b1;
      end
      BRANCH: begin
        imm_fmt_o = IMM_B;
        branch_o  = 1'b1;
      end
      JAL, JALR: begin
        // ALU forms the link address pc + 4
        imm_fmt_o = (opcode == JAL) ? IMM_J : IMM_I;
        src_a_o   = SRC_A_PC;
        src_b_o   = SRC_B_FOUR;
        w_src_o   = W_LINK;
        reg_wen_o = 1'b1;
        jump_o    = 1'b1;
      end
      IMMED: begin
        imm_fmt_o = IMM_I;
        src_b_o   = SRC_B_IMM;
        reg_wen_o = 1'b1;
      end
      REGREG: begin
        reg_wen_o = 1'b1;
        illegal_o = (funct7 != BASE_FUNCT7) && (funct7 != ALT_FUNCT7) &&
                    (funct7 != MULDIV_FUNCT7);
      end
      LUI: begin
        imm_fmt_o = IMM_U;
        src_b_o   = SRC_B_IMM;
        w_src_o   = W_IMM;
        reg_wen_o = 1'b1;
      end
      AUIPC: begin
        imm_fmt_o = IMM_U;
        src_a_o   = SRC_A_PC;
        src_b_o   = SRC_B_IMM;
        reg_wen_o = 1'b1;
      end
      SYSTEM: begin
        w_src_o = W_CSR;
        if (funct3 == F3_PRIV) begin
          case (imm12)
            PRIV_ECALL:  sys_op_o = SYS_ECALL;
            PRIV_EBREAK: sys_op_o = SYS_EBREAK;
            PRIV_MRET:   sys_op_o = SYS_MRET;
            PRIV_WFI:    sys_op_o = SYS_WFI;
            default:     sys_op_o = SYS_NONE;
          endcase
        end else begin
          // funct3[2] selects the zimm form
          csr_op_o  = csr_op_t'(funct3[1:0]);
          csr_imm_o = funct3[2];
          reg_wen_o = (csr_op_o != CSR_NONE);
        end
      end
      MISCMEM: begin
        if (funct3 == F3_FENCEI) begin
          sys_op_o = SYS_FENCEI;
        end
      end
      default: illegal_o = 1'b1;
    endcase

    // x0 is never written
    if (rd == '0) begin
      reg_wen_o = 1'b0;
    end
    if (instr_i == '0) begin
      illegal_o = 1'b1;
    end
  end

  assign load_type_o   = load_t'(funct3);
  assign branch_type_o = branch_t'(funct3);

  // functional unit, funct3[2] splits divide from multiply
  always_comb begin
    if (opcode == REGREG && funct7 == MULDIV_FUNCT7) begin
      sfu_o = funct3[2] ? SFU_DIV : SFU_MUL;
    end else begin
      sfu_o = SFU_ARITH;
    end
  end

  assign mul_high_o  = (sfu_o == SFU_MUL) && (|funct3[1:0]);
  assign div_rem_o   = (sfu_o == SFU_DIV) && funct3[1];
  assign is_signed_o = !((funct3 == F3_MULHU) || (funct3 == F3_DIVU) ||
                         (funct3 == F3_REMU));

endmodule

// File: hdl/decode_register.sv
//######################################################################
// decode pipeline register
// picks the immediate, captures register fields and control bits,
// holds on stall, kills on flush and turns illegal words into traps
//######################################################################

`timescale 1ns/1ps

module decode_register (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      valid_i,
  input  logic                      stall_i,
  input  logic                      flush_i,
  input  rv32_decode_pkg::word_t    instr_i,
  input  rv32_decode_pkg::imm_fmt_t imm_fmt_i,
  input  rv32_decode_pkg::alu_op_t  alu_op_i,
  input  rv32_decode_pkg::src_a_t   src_a_i,
  input  rv32_decode_pkg::src_b_t   src_b_i,
  input  rv32_decode_pkg::w_src_t   w_src_i,
  input  logic                      reg_wen_i,
  input  logic                      mem_ren_i,
  input  logic                      mem_wen_i,
  input  rv32_decode_pkg::load_t    load_type_i,
  input  logic                      branch_i,
  input  rv32_decode_pkg::branch_t  branch_type_i,
  input  logic                      jump_i,
  input  rv32_decode_pkg::sfu_t     sfu_i,
  input  logic                      mul_high_i,
  input  logic                      div_rem_i,
  input  logic                      is_signed_i,
  input  rv32_decode_pkg::csr_op_t  csr_op_i,
  input  logic                      csr_imm_i,
  input  rv32_decode_pkg::sys_op_t  sys_op_i,
  input  logic                      illegal_i,
  input  rv32_decode_pkg::word_t    imm_i_i,
  input  rv32_decode_pkg::word_t    imm_s_i,
  input  rv32_decode_pkg::word_t    imm_b_i,
  input  rv32_decode_pkg::word_t    imm_u_i,
  input  rv32_decode_pkg::word_t    imm_j_i,
  output logic                      valid_o,
  output logic                      trap_o,
  output rv32_decode_pkg::reg_idx_t rs1_o,
  output rv32_decode_pkg::reg_idx_t rs2_o,
  output rv32_decode_pkg::reg_idx_t rd_o,
  output rv32_decode_pkg::csr_addr_t csr_addr_o,
  output rv32_decode_pkg::word_t    imm_o,
  output rv32_decode_pkg::alu_op_t  alu_op_o,
  output rv32_decode_pkg::src_a_t   src_a_o,
  output rv32_decode_pkg::src_b_t   src_b_o,
  output rv32_decode_pkg::w_src_t   w_src_o,
  output logic                      reg_wen_o,
  output logic                      mem_ren_o,
  output logic                      mem_wen_o,
  output rv32_decode_pkg::load_t    load_type_o,
  output logic                      branch_o,
  output rv32_decode_pkg::branch_t  branch_type_o,
  output logic                      jump_o,
  output rv32_decode_pkg::sfu_t     sfu_o,
  output logic                      mul_high_o,
  output logic                      div_rem_o,
  output logic                      is_signed_o,
  output rv32_decode_pkg::csr_op_t  csr_op_o,
  output logic                      csr_imm_o,
  output rv32_decode_pkg::sys_op_t  sys_op_o
);
  import rv32_decode_pkg::*;

  word_t imm_sel;
  logic  live;

  always_comb begin
    case (imm_fmt_i)
      IMM_I:   imm_sel = imm_i_i;
      IMM_S:   imm_sel = imm_s_i;
      IMM_B:   imm_sel = imm_b_i;
      IMM_U:   imm_sel = imm_u_i;
      IMM_J:   imm_sel = imm_j_i;
      default: imm_sel = '0;
    endcase
  end

  // a valid, legal instruction may raise side effects
  assign live = valid_i & ~illegal_i;

  // control state, flush wins over stall
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      valid_o   <= 1'b0;
      trap_o    <= 1'b0;
      reg_wen_o <= 1'b0;
      mem_ren_o <= 1'b0;
      mem_wen_o <= 1'b0;
      branch_o  <= 1'b0;
      jump_o    <= 1'b0;
      csr_op_o  <= CSR_NONE;
      sys_op_o  <= SYS_NONE;
    end else if (!stall_i) begin
      valid_o   <= valid_i;
      trap_o    <= valid_i & illegal_i;
      reg_wen_o <= live & reg_wen_i;
      mem_ren_o <= live & mem_ren_i;
      mem_wen_o <= live & mem_wen_i;
      branch_o  <= live & branch_i;
      jump_o    <= live & jump_i;
      csr_op_o  <= live ? csr_op_i : CSR_NONE;
      sys_op_o  <= live ? sys_op_i : SYS_NONE;
    end
  end

  // payload, only meaningful while valid_o is high
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      rs1_o         <= instr_i[19:15];
      rs2_o         <= instr_i[24:20];
      rd_o          <= instr_i[11:7];
      csr_addr_o    <= instr_i[31:20];
      imm_o         <= imm_sel;
      alu_op_o      <= alu_op_i;
      src_a_o       <= src_a_i;
      src_b_o       <= src_b_i;
      w_src_o       <= w_src_i;
      load_type_o   <= load_type_i;
      branch_type_o <= branch_type_i;
      sfu_o         <= sfu_i;
      mul_high_o    <= mul_high_i;
      div_rem_o     <= div_rem_i;
      is_signed_o   <= is_signed_i;
      csr_imm_o     <= csr_imm_i;
    end
  end

endmodule

// File: hdl/decode_stage.sv
//######################################################################
// RV32IM decode stage
// control decoder and immediate generator feeding the pipeline register
//######################################################################

`timescale 1ns/1ps

module decode_stage (
  input  logic                      clk,
  input  logic                      rst_i,
  input  rv32_decode_pkg::word_t    instr_i,
  input  logic                      instr_valid_i,
  input  logic                      stall_i,
  input  logic                      flush_i,
  output logic                      valid_o,
  output logic                      trap_o,
  output rv32_decode_pkg::reg_idx_t rs1_o,
  output rv32_decode_pkg::reg_idx_t rs2_o,
  output rv32_decode_pkg::reg_idx_t rd_o,
  output rv32_decode_pkg::csr_addr_t csr_addr_o,
  output rv32_decode_pkg::word_t    imm_o,
  output rv32_decode_pkg::alu_op_t  alu_op_o,
  output rv32_decode_pkg::src_a_t   src_a_o,
  output rv32_decode_pkg::src_b_t   src_b_o,
  output rv32_decode_pkg::w_src_t   w_src_o,
  output logic                      reg_wen_o,
  output logic                      mem_ren_o,
  output logic                      mem_wen_o,
  output rv32_decode_pkg::load_t    load_type_o,
  output logic                      branch_o,
  output rv32_decode_pkg::branch_t  branch_type_o,
  output logic                      jump_o,
  output rv32_decode_pkg::sfu_t     sfu_o,
  output logic                      mul_high_o,
  output logic                      div_rem_o,
  output logic                      is_signed_o,
  output rv32_decode_pkg::csr_op_t  csr_op_o,
  output logic                      csr_imm_o,
  output rv32_decode_pkg::sys_op_t  sys_op_o
);
  import rv32_decode_pkg::*;

  imm_fmt_t imm_fmt;
  alu_op_t  alu_op;
  src_a_t   src_a;
  src_b_t   src_b;
  w_src_t   w_src;
  logic     reg_wen;
  logic     mem_ren;
  logic     mem_wen;
  load_t    load_type;
  logic     branch;
  branch_t  branch_type;
  logic     jump;
  sfu_t     sfu;
  logic     mul_high;
  logic     div_rem;
  logic     is_signed;
  csr_op_t  csr_op;
  logic     csr_imm;
  sys_op_t  sys_op;
  logic     illegal;
  word_t    imm_i;
  word_t    imm_s;
  word_t    imm_b;
  word_t    imm_u;
  word_t    imm_j;

  control_decoder u_ctrl (
    .instr_i       (instr_i),
    .imm_fmt_o     (imm_fmt),
    .alu_op_o      (alu_op),
    .src_a_o       (src_a),
    .src_b_o       (src_b),
    .w_src_o       (w_src),
    .reg_wen_o     (reg_wen),
    .mem_ren_o     (mem_ren),
    .mem_wen_o     (mem_wen),
    .load_type_o   (load_type),
    .branch_o      (branch),
    .branch_type_o (branch_type),
    .jump_o        (jump),
    .sfu_o         (sfu),
    .mul_high_o    (mul_high),
    .div_rem_o     (div_rem),
    .is_signed_o   (is_signed),
    .csr_op_o      (csr_op),
    .csr_imm_o     (csr_imm),
    .sys_op_o      (sys_op),
    .illegal_o     (illegal)
  );

  imm_generator u_imm (
    .instr_i (instr_i),
    .imm_i_o (imm_i),
    .imm_s_o (imm_s),
    .imm_b_o (imm_b),
    .imm_u_o (imm_u),
    .imm_j_o (imm_j)
  );

  decode_register u_reg (
    .clk           (clk),
    .rst_i         (rst_i),
    .valid_i       (instr_valid_i),
    .stall_i       (stall_i),
    .flush_i       (flush_i),
    .instr_i       (instr_i),
    .imm_fmt_i     (imm_fmt),
    .alu_op_i      (alu_op),
    .src_a_i       (src_a),
    .src_b_i       (src_b),
    .w_src_i       (w_src),
    .reg_wen_i     (reg_wen),
    .mem_ren_i     (mem_ren),
    .mem_wen_i     (mem_wen),
    .load_type_i   (load_type),
    .branch_i      (branch),
    .branch_type_i (branch_type),
    .jump_i        (jump),
    .sfu_i         (sfu),
    .mul_high_i    (mul_high),
    .div_rem_i     (div_rem),
    .is_signed_i   (is_signed),
    .csr_op_i      (csr_op),
    .csr_imm_i     (csr_imm),
    .sys_op_i      (sys_op),
    .illegal_i     (illegal),
    .imm_i_i       (imm_i),
    .imm_s_i       (imm_s),
    .imm_b_i       (imm_b),
    .imm_u_i       (imm_u),
    .imm_j_i       (imm_j),
    .valid_o       (valid_o),
    .trap_o        (trap_o),
    .rs1_o         (rs1_o),
    .rs2_o         (rs2_o),
    .rd_o          (rd_o),
    .csr_addr_o    (csr_addr_o),
    .imm_o         (imm_o),
    .alu_op_o      (alu_op_o),
    .src_a_o       (src_a_o),
    .src_b_o       (src_b_o),
    .w_src_o       (w_src_o),
    .reg_wen_o     (reg_wen_o),
    .mem_ren_o     (mem_ren_o),
    .mem_wen_o     (mem_wen_o),
    .load_type_o   (load_type_o),
    .branch_o      (branch_o),
    .branch_type_o (branch_type_o),
    .jump_o        (jump_o),
    .sfu_o         (sfu_o),
    .mul_high_o    (mul_high_o),
    .div_rem_o     (div_rem_o),
    .is_signed_o   (is_signed_o),
    .csr_op_o      (csr_op_o),
    .csr_imm_o     (csr_imm_o),
    .sys_op_o      (sys_op_o)
  );

endmodule

// File: hdl/imm_generator.sv
//######################################################################
// immediate generator
// rebuilds the I, S, B, U and J immediates, sign-extended to 32 bits
//######################################################################

`timescale 1ns/1ps

module imm_generator (
  input  rv32_decode_pkg::word_t instr_i,
  output rv32_decode_pkg::word_t imm_i_o,
  output rv32_decode_pkg::word_t imm_s_o,
  output rv32_decode_pkg::word_t imm_b_o,
  output rv32_decode_pkg::word_t imm_u_o,
  output rv32_decode_pkg::word_t imm_j_o
);

  logic sign;

  // every format takes its sign from bit 31
  assign sign = instr_i[31];

  assign imm_i_o = {{20{sign}}, instr_i[31:20]};

  assign imm_s_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};

  // branch offsets are halfword aligned
  assign imm_b_o = {{19{sign}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

  assign imm_u_o = {instr_i[31:12], 12'b0};

  assign imm_j_o = {{11{sign}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

endmodule

// File: hdl/rv32_decode_pkg.sv
//######################################################################
// RV32IM decode package
// shared field types, opcode and funct encodings and control enums
// for the decode stage and its testbench
//######################################################################

package rv32_decode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // funct7 values accepted on register-register ops
  localparam funct7_t BASE_FUNCT7   = 7'b000_0000;
  localparam funct7_t ALT_FUNCT7    = 7'b010_0000;
  localparam funct7_t MULDIV_FUNCT7 = 7'b000_0001;

  // integer op funct3
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // unsigned forms of the M extension
  localparam funct3_t F3_MULHU = 3'b011;
  localparam funct3_t F3_DIVU  = 3'b101;
  localparam funct3_t F3_REMU  = 3'b111;

  // system and misc-mem funct3
  localparam funct3_t F3_PRIV   = 3'b000;
  localparam funct3_t F3_FENCEI = 3'b001;

  // imm[11:0] of the privileged instructions
  localparam logic [11:0] PRIV_ECALL  = 12'h000;
  localparam logic [11:0] PRIV_EBREAK = 12'h001;
  localparam logic [11:0] PRIV_WFI    = 12'h105;
  localparam logic [11:0] PRIV_MRET   = 12'h302;

  typedef enum logic [6:0] {
    LOAD    = 7'b000_0011,
    MISCMEM = 7'b000_1111,
    IMMED   = 7'b001_0011,
    AUIPC   = 7'b001_0111,
    STORE   = 7'b010_0011,
    REGREG  = 7'b011_0011,
    LUI     = 7'b011_0111,
    BRANCH  = 7'b110_0011,
    JALR    = 7'b110_0111,
    JAL     = 7'b110_1111,
    SYSTEM  = 7'b111_0011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  typedef enum logic [2:0] {
    IMM_NONE = 3'd0,
    IMM_I    = 3'd1,
    IMM_S    = 3'd2,
    IMM_B    = 3'd3,
    IMM_U    = 3'd4,
    IMM_J    = 3'd5
  } imm_fmt_t;

  // write-back source
  typedef enum logic [2:0] {
    W_MEM  = 3'd0,
    W_LINK = 3'd1,
    W_IMM  = 3'd2,
    W_ALU  = 3'd3,
    W_CSR  = 3'd4
  } w_src_t;

  typedef enum logic [1:0] {
    SRC_A_REG = 2'd0,
    SRC_A_PC  = 2'd1
  } src_a_t;

  typedef enum logic [1:0] {
    SRC_B_REG  = 2'd0,
    SRC_B_IMM  = 2'd1,
    SRC_B_FOUR = 2'd2
  } src_b_t;

  typedef enum logic [1:0] {
    SFU_ARITH = 2'd0,
    SFU_MUL   = 2'd1,
    SFU_DIV   = 2'd2
  } sfu_t;

  // load width, encoded as funct3
  typedef enum logic [2:0] {
    LD_B  = 3'b000,
    LD_H  = 3'b001,
    LD_W  = 3'b010,
    LD_BU = 3'b100,
    LD_HU = 3'b101
  } load_t;

  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_t;

  // matches funct3[1:0] of the CSR instructions
  typedef enum logic [1:0] {
    CSR_NONE = 2'd0,
    CSR_SWAP = 2'd1,
    CSR_SET  = 2'd2,
    CSR_CLR  = 2'd3
  } csr_op_t;

  typedef enum logic [2:0] {
    SYS_NONE   = 3'd0,
    SYS_ECALL  = 3'd1,
    SYS_EBREAK = 3'd2,
    SYS_MRET   = 3'd3,
    SYS_WFI    = 3'd4,
    SYS_FENCEI = 3'd5
  } sys_op_t;

endpackage

// File: testbench/decode_input.txt
// ctl(bit1 stall, bit0 flush) instr | expected: valid trap alu imm rd
// reg_wen mem_ren mem_wen branch jump sfu csr_op csr_addr sys_op
0 002081B3 1 0 0 00000000 03 1 0 0 0 0 0 0 002 0
0 407302B3 1 0 1 00000000 05 1 0 0 0 0 0 0 407 0
0 40A4D433 1 0 4 00000000 08 1 0 0 0 0 0 0 40A 0
0 00325213 1 0 3 00000003 04 1 0 0 0 0 0 0 003 0
0 00508013 1 0 0 00000005 00 0 0 0 0 0 0 0 005 0
0 FF014393 1 0 7 FFFFFFF0 07 1 0 0 0 0 0 0 FF0 0
0 FFC12503 1 0 0 FFFFFFFC 0A 1 1 0 0 0 0 0 FFC 0
0 FEB12C23 1 0 0 FFFFFFF8 18 0 0 1 0 0 0 0 FEB 0
0 FE208CE3 1 0 0 FFFFFFF8 19 0 0 0 1 0 0 0 FE2 0
0 FFDFF0EF 1 0 0 FFFFFFFC 01 1 0 0 0 1 0 0 FFD 0
0 00008067 1 0 0 00000000 00 0 0 0 0 1 0 0 000 0
0 123452B7 1 0 0 12345000 05 1 0 0 0 0 0 0 123 0
2 00000013 1 0 0 12345000 05 1 0 0 0 0 0 0 123 0
0 FFFFF317 1 0 0 FFFFF000 06 1 0 0 0 0 0 0 FFF 0
0 02E68633 1 0 0 00000000 0C 1 0 0 0 0 1 0 02E 0
0 031857B3 1 0 3 00000000 0F 1 0 0 0 0 2 0 031 0
0 300110F3 1 0 0 00000000 01 1 0 0 0 0 0 1 300 0
0 341261F3 1 0 0 00000000 03 1 0 0 0 0 0 2 341 0
0 00000073 1 0 0 00000000 00 0 0 0 0 0 0 0 000 1
0 00100073 1 0 0 00000000 00 0 0 0 0 0 0 0 001 2
0 30200073 1 0 0 00000000 00 0 0 0 0 0 0 0 302 3
0 10500073 1 0 0 00000000 00 0 0 0 0 0 0 0 105 4
0 0000100F 1 0 0 00000000 00 0 0 0 0 0 0 0 000 5
0 00000000 1 1 0 00000000 00 0 0 0 0 0 0 0 000 0
0 203100B3 1 1 0 00000000 01 0 0 0 0 0 0 0 203 0
0 FFFFFFFF 1 1 0 00000000 1F 0 0 0 0 0 0 0 FFF 0
1 00B50533 0 0 0 00000000 00 0 0 0 0 0 0 0 000 0
3 00B50533 0 0 0 00000000 00 0 0 0 0 0 0 0 000 0
0 00B50533 1 0 0 00000000 0A 1 0 0 0 0 0 0 00B 0

// File: testbench/tb_decode_stage.sv
//######################################################################
// decode stage testbench
// replays instruction vectors from a data file and checks the
// registered control fields one cycle after each entry is sampled
//######################################################################

`timescale 1ns/1ps

module tb_decode_stage;
  import rv32_decode_pkg::*;

  localparam int ENTRY_COUNT    = 29;
  localparam int FIELD_COUNT    = 16;
  localparam int MAX_GAPS       = 8;
  localparam int TIMEOUT_CYCLES = 3 * ENTRY_COUNT + 50;

  // column order of one data file row
  localparam int COL_CTL   = 0;
  localparam int COL_INSTR = 1;
  localparam int COL_VALID = 2;
  localparam int COL_TRAP  = 3;
  localparam int COL_ALU   = 4;
  localparam int COL_IMM   = 5;
  localparam int COL_RD    = 6;
  localparam int COL_WEN   = 7;
  localparam int COL_REN   = 8;
  localparam int COL_MWEN  = 9;
  localparam int COL_BR    = 10;
  localparam int COL_JMP   = 11;
  localparam int COL_SFU   = 12;
  localparam int COL_CSR   = 13;
  localparam int COL_CADDR = 14;
  localparam int COL_SYS   = 15;

  // what was driven on the previous edge
  localparam int NO_ENTRY   = -1;
  localparam int IDLE_ENTRY = -2;

  logic       clk = 1'b0;
  logic       rst_i;
  word_t      instr_i;
  logic       instr_valid_i;
  logic       stall_i;
  logic       flush_i;
  logic       valid_o;
  logic       trap_o;
  reg_idx_t   rs1_o;
  reg_idx_t   rs2_o;
  reg_idx_t   rd_o;
  csr_addr_t  csr_addr_o;
  word_t      imm_o;
  alu_op_t    alu_op_o;
  src_a_t     src_a_o;
  src_b_t     src_b_o;
  w_src_t     w_src_o;
  logic       reg_wen_o;
  logic       mem_ren_o;
  logic       mem_wen_o;
  load_t      load_type_o;
  logic       branch_o;
  branch_t    branch_type_o;
  logic       jump_o;
  sfu_t       sfu_o;
  logic       mul_high_o;
  logic       div_rem_o;
  logic       is_signed_o;
  csr_op_t    csr_op_o;
  logic       csr_imm_o;
  sys_op_t    sys_op_o;

  logic [31:0] vec_mem [ENTRY_COUNT * FIELD_COUNT];
  integer      seed;
  int          cycle_count = 0;
  int          check_count = 0;
  int          gap_count = 0;
  int          pending;
  string       context_name = "reset";
  // word held by the register after the last unstalled entry
  word_t       held_instr = '0;

  always #50 clk = ~clk;

  decode_stage dut0 (
    .clk           (clk),
    .rst_i         (rst_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .stall_i       (stall_i),
    .flush_i       (flush_i),
    .valid_o       (valid_o),
    .trap_o        (trap_o),
    .rs1_o         (rs1_o),
    .rs2_o         (rs2_o),
    .rd_o          (rd_o),
    .csr_addr_o    (csr_addr_o),
    .imm_o         (imm_o),
    .alu_op_o      (alu_op_o),
    .src_a_o       (src_a_o),
    .src_b_o       (src_b_o),
    .w_src_o       (w_src_o),
    .reg_wen_o     (reg_wen_o),
    .mem_ren_o     (mem_ren_o),
    .mem_wen_o     (mem_wen_o),
    .load_type_o   (load_type_o),
    .branch_o      (branch_o),
    .branch_type_o (branch_type_o),
    .jump_o        (jump_o),
    .sfu_o         (sfu_o),
    .mul_high_o    (mul_high_o),
    .div_rem_o     (div_rem_o),
    .is_signed_o   (is_signed_o),
    .csr_op_o      (csr_op_o),
    .csr_imm_o     (csr_imm_o),
    .sys_op_o      (sys_op_o)
  );

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("error: %s %s = %h, expected %h", context_name, name, got, expected);
    $display("TESTS FAILED");
    $fatal(1, "mismatch on %s", name);
  endtask

  // no side effects may leave the stage
  task automatic check_quiet();
    assert (valid_o === 1'b0) else report_mismatch("valid_o", valid_o, 0);
    assert (trap_o === 1'b0) else report_mismatch("trap_o", trap_o, 0);
    assert (reg_wen_o === 1'b0) else report_mismatch("reg_wen_o", reg_wen_o, 0);
    assert (mem_ren_o === 1'b0) else report_mismatch("mem_ren_o", mem_ren_o, 0);
    assert (mem_wen_o === 1'b0) else report_mismatch("mem_wen_o", mem_wen_o, 0);
    assert (branch_o === 1'b0) else report_mismatch("branch_o", branch_o, 0);
    assert (jump_o === 1'b0) else report_mismatch("jump_o", jump_o, 0);
    assert (csr_op_o === CSR_NONE) else report_mismatch("csr_op_o", csr_op_o, CSR_NONE);
    assert (sys_op_o === SYS_NONE) else report_mismatch("sys_op_o", sys_op_o, SYS_NONE);
  endtask

  // fields without a data file column, rebuilt from the held word
  task automatic compare_derived_fields(input word_t instr);
    logic [6:0] op;
    logic [2:0] f3;
    logic       muldiv;
    src_a_t     exp_a;
    src_b_t     exp_b;
    w_src_t     exp_w;
    logic       exp_high;
    logic       exp_rem;
    logic       exp_signed;
    logic       exp_zimm;
    op     = instr[6:0];
    f3     = instr[14:12];
    muldiv = (op == REGREG) && (instr[31:25] == MULDIV_FUNCT7);
    exp_a  = SRC_A_REG;
    exp_b  = SRC_B_REG;
    exp_w  = W_ALU;
    case (op)
      LOAD: begin
        exp_b = SRC_B_IMM;
        exp_w = W_MEM;
      end
      STORE, IMMED: begin
        exp_b = SRC_B_IMM;
      end
      LUI: begin
        exp_b = SRC_B_IMM;
        exp_w = W_IMM;
      end
      AUIPC: begin
        exp_a = SRC_A_PC;
        exp_b = SRC_B_IMM;
      end
      // link address is pc + 4
      JAL, JALR: begin
        exp_a = SRC_A_PC;
        exp_b = SRC_B_FOUR;
        exp_w = W_LINK;
      end
      SYSTEM: begin
        exp_w = W_CSR;
      end
      default: begin
      end
    endcase
    // mulh, mulhsu and mulhu return the upper half
    exp_high   = muldiv && (f3 == 3'b001 || f3 == 3'b010 || f3 == 3'b011);
    // rem and remu
    exp_rem    = muldiv && (f3 == 3'b110 || f3 == 3'b111);
    // mulhu, divu and remu take unsigned operands
    exp_signed = !(f3 == 3'b011 || f3 == 3'b101 || f3 == 3'b111);
    // csrrwi, csrrsi and csrrci
    exp_zimm   = (op == SYSTEM) && (f3 == 3'b101 || f3 == 3'b110 || f3 == 3'b111);

    assert (rs1_o === instr[19:15])
      else report_mismatch("rs1_o", rs1_o, instr[19:15]);
    assert (rs2_o === instr[24:20])
      else report_mismatch("rs2_o", rs2_o, instr[24:20]);
    assert (src_a_o === exp_a)
      else report_mismatch("src_a_o", src_a_o, exp_a);
    assert (src_b_o === exp_b)
      else report_mismatch("src_b_o", src_b_o, exp_b);
    assert (w_src_o === exp_w)
      else report_mismatch("w_src_o", w_src_o, exp_w);
    assert (mul_high_o === exp_high)
      else report_mismatch("mul_high_o", mul_high_o, exp_high);
    assert (div_rem_o === exp_rem)
      else report_mismatch("div_rem_o", div_rem_o, exp_rem);
    assert (csr_imm_o === exp_zimm)
      else report_mismatch("csr_imm_o", csr_imm_o, exp_zimm);
    if (op == LOAD) begin
      assert (load_type_o === f3)
        else report_mismatch("load_type_o", load_type_o, f3);
    end
    if (op == BRANCH) begin
      assert (branch_type_o === f3)
        else report_mismatch("branch_type_o", branch_type_o, f3);
    end
    if (muldiv) begin
      assert (is_signed_o === exp_signed)
        else report_mismatch("is_signed_o", is_signed_o, exp_signed);
    end
  endtask

  task automatic check_entry(input int idx);
    logic [31:0] row [FIELD_COUNT];
    int          c;
    for (c = 0; c < FIELD_COUNT; c++) begin
      row[c] = vec_mem[idx * FIELD_COUNT + c];
    end
    // a stalled entry leaves the earlier word in place
    if (!row[COL_CTL][1]) begin
      held_instr = row[COL_INSTR];
    end
    context_name = $sformatf("entry %0d", idx);
    assert (valid_o === row[COL_VALID][0])
      else report_mismatch("valid_o", valid_o, row[COL_VALID]);
    assert (trap_o === row[COL_TRAP][0])
      else report_mismatch("trap_o", trap_o, row[COL_TRAP]);
    assert (reg_wen_o === row[COL_WEN][0])
      else report_mismatch("reg_wen_o", reg_wen_o, row[COL_WEN]);
    assert (mem_ren_o === row[COL_REN][0])
      else report_mismatch("mem_ren_o", mem_ren_o, row[COL_REN]);
    assert (mem_wen_o === row[COL_MWEN][0])
      else report_mismatch("mem_wen_o", mem_wen_o, row[COL_MWEN]);
    assert (branch_o === row[COL_BR][0])
      else report_mismatch("branch_o", branch_o, row[COL_BR]);
    assert (jump_o === row[COL_JMP][0])
      else report_mismatch("jump_o", jump_o, row[COL_JMP]);
    assert (csr_op_o === row[COL_CSR][1:0])
      else report_mismatch("csr_op_o", csr_op_o, row[COL_CSR]);
    assert (sys_op_o === row[COL_SYS][2:0])
      else report_mismatch("sys_op_o", sys_op_o, row[COL_SYS]);
    // payload only counts with valid_o high
    if (row[COL_VALID][0]) begin
      assert (alu_op_o === row[COL_ALU][3:0])
        else report_mismatch("alu_op_o", alu_op_o, row[COL_ALU]);
      assert (imm_o === row[COL_IMM])
        else report_mismatch("imm_o", imm_o, row[COL_IMM]);
      assert (rd_o === row[COL_RD][4:0])
        else report_mismatch("rd_o", rd_o, row[COL_RD]);
      assert (sfu_o === row[COL_SFU][1:0])
        else report_mismatch("sfu_o", sfu_o, row[COL_SFU]);
      assert (csr_addr_o === row[COL_CADDR][11:0])
        else report_mismatch("csr_addr_o", csr_addr_o, row[COL_CADDR]);
      if (!row[COL_TRAP][0]) begin
        compare_derived_fields(held_instr);
      end
    end
    check_count++;
  endtask

  task automatic check_pending(input int p);
    if (p == IDLE_ENTRY) begin
      context_name = "idle gap";
      check_quiet();
    end else if (p >= 0) begin
      check_entry(p);
    end
  endtask

  task automatic apply_entry(input int idx);
    logic [31:0] ctl;
    ctl = vec_mem[idx * FIELD_COUNT + COL_CTL];
    stall_i       <= ctl[1];
    flush_i       <= ctl[0];
    instr_i       <= vec_mem[idx * FIELD_COUNT + COL_INSTR];
    instr_valid_i <= 1'b1;
  endtask

  task automatic apply_idle();
    stall_i       <= 1'b0;
    flush_i       <= 1'b0;
    instr_i       <= '0;
    instr_valid_i <= 1'b0;
  endtask

  initial begin
    seed          = 32'hed39_1036;
    rst_i         = 1'b1;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    stall_i       = 1'b0;
    flush_i       = 1'b0;
    $readmemh("testbench/decode_input.txt", vec_mem);
    if ($isunknown(vec_mem[ENTRY_COUNT * FIELD_COUNT - 1])) begin
      $display("the data file could not be read completely");
      $display("TESTS FAILED");
      $fatal(1, "no stimulus");
    end

    repeat (5) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    check_quiet();

    pending = NO_ENTRY;
    for (int k = 0; k < ENTRY_COUNT; k++) begin
      // a gap before a stalled entry would change what it holds
      if (gap_count < MAX_GAPS && !vec_mem[k * FIELD_COUNT + COL_CTL][1] &&
          (($random(seed) & 3) == 0)) begin
        @(posedge clk);
        apply_idle();
        @(negedge clk);
        check_pending(pending);
        pending = IDLE_ENTRY;
        gap_count++;
      end
      @(posedge clk);
      apply_entry(k);
      @(negedge clk);
      check_pending(pending);
      pending = k;
    end

    // drain the last entry
    @(posedge clk);
    apply_idle();
    @(negedge clk);
    check_pending(pending);

    if (check_count == ENTRY_COUNT) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("only %0d of %0d entries were checked", check_count, ENTRY_COUNT);
      $display("TESTS FAILED");
      $fatal(1, "incomplete run");
    end
  end

endmodule
